//--- prbs_bist.f
design/prbs_pkg.sv
design/prbs_gen.sv
design/prbs_check.sv
design/prbs_err_track.sv
design/prbs_bist.sv
dv/prbs_bist_tb.sv

//--- Makefile
# Verilator build and run for the PRBS-7 BIST testbench

VERILATOR ?= verilator
TOP       ?= prbs_bist_tb
FILELIST  ?= prbs_bist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, scan $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "All checks passed" $(LOG); then echo "Simulation gave no result"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/prbs_bist_tb.sv
// Testbench for the PRBS-7 BIST top level.
// Runs loopback, single-bit injections, external all-zero data and a
// counter clear. A cycle model built from the PRBS and lock rules is
// compared with the DUT outputs on every falling clock edge.

`default_nettype none

module prbs_bist_tb;

    localparam int W          = prbs_pkg::DATA_W;
    localparam int ORDER      = prbs_pkg::PRBS_ORDER;
    localparam int TAP        = prbs_pkg::PRBS_TAP;
    localparam int LOCK_WORDS = 8;
    localparam int CNT_W      = 16;
    localparam int CNT_MAX    = (1 << CNT_W) - 1;
    localparam int CLK_PERIOD = 20;
    localparam int N_INJ      = 6;
    // Reset, idle, first lock, loopback run, injections, zero data, clear, relock
    localparam int PLAN_CYCLES = 8 + 1 + (LOCK_WORDS + 5) + 24 + (N_INJ + 1) * 12 + 19 + 4
                                 + (LOCK_WORDS + 6);

    logic                   clk_i, resetn_i, gen_en_i, inject_i, loopback_i;
    logic [2:0]             inject_pos_i;
    logic [W-1:0]           rx_data_i, tx_data_o;
    logic                   rx_valid_i, clear_i, tx_valid_o, locked_o, error_o;
    logic [CNT_W-1:0]       err_count_o;

    // Model state with bit 0 oldest in both histories
    logic [ORDER-1:0]       m_lfsr;
    logic [ORDER-1:0]       m_hist;
    logic [W-1:0]           m_tx_data;
    logic                   m_tx_valid, m_stat_valid, m_stat_zero, m_locked, m_error;
    int                     m_stat_pop, m_count, m_good, m_bad;

    prbs_bist #(
        .LOCK_WORDS (LOCK_WORDS),
        .CNT_W      (CNT_W)
    ) prbs_bist_inst (
        .clk_i (clk_i), .resetn_i (resetn_i), .gen_en_i (gen_en_i), .inject_i (inject_i),
        .inject_pos_i (inject_pos_i), .loopback_i (loopback_i), .rx_data_i (rx_data_i),
        .rx_valid_i (rx_valid_i), .clear_i (clear_i), .tx_data_o (tx_data_o),
        .tx_valid_o (tx_valid_o), .locked_o (locked_o), .error_o (error_o),
        .err_count_o (err_count_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // ==============================
    // Reference functions
    // ==============================
    // Next word from the last ORDER output bits by b[n] = b[n-7] ^ b[n-6]
    function automatic logic [W-1:0] next_prbs_word(input logic [ORDER-1:0] past);
        logic [W+ORDER-1:0] seq;
        seq = {{W{1'b0}}, past};
        for (int n = ORDER; n < W + ORDER; n++)
            seq[n] = seq[n-ORDER] ^ seq[n-TAP];
        return seq[W+ORDER-1:ORDER];
    endfunction

    // Replays the received bits one at a time through a sliding window
    function automatic int count_flagged_bits(input logic [ORDER-1:0] hist,
                                              input logic [W-1:0] data);
        logic [ORDER-1:0] win;
        logic             predicted;
        int               cnt;
        win = hist;
        cnt = 0;
        for (int i = 0; i < W; i++)
        begin
            // win[0] lies seven bits back, win[1] six bits back
            predicted = win[0] ^ win[ORDER-TAP];
            if (data[i] != predicted)
                cnt++;
            win = {data[i], win[ORDER-1:1]};
        end
        return cnt;
    endfunction

    // ==============================
    // Compare tasks
    // ==============================
    task automatic check_word(input string name, input logic [W-1:0] exp,
                              input logic [W-1:0] act);
        if (act !== exp)
        begin
            $display("ERROR t=%0t %s expected=%h actual=%h", $time, name, exp, act);
            $display("Checks failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("ERROR t=%0t %s expected=%b actual=%b", $time, name, exp, act);
            $display("Checks failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic check_count(input string name, input logic [CNT_W-1:0] exp,
                               input logic [CNT_W-1:0] act);
        if (act !== exp)
        begin
            $display("ERROR t=%0t %s expected=%0d actual=%0d", $time, name, exp, act);
            $display("Checks failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // ==============================
    // Cycle model and comparison
    // ==============================
    always @(negedge clk_i)
    begin : model_step
        logic         cin_valid;
        logic [W-1:0] cin_data;
        logic [W-1:0] clean_word;
        if (!resetn_i)
        begin
            m_lfsr       = prbs_pkg::PRBS_SEED;
            m_hist       = '0;
            m_tx_valid   = 1'b0;
            m_tx_data    = '0;
            m_stat_valid = 1'b0;
            m_stat_zero  = 1'b0;
            m_stat_pop   = 0;
            m_locked     = 1'b0;
            m_error      = 1'b1;
            m_count      = 0;
            m_good       = 0;
            m_bad        = 0;
        end
        else
        begin
            check_flag("tx_valid_o", m_tx_valid, tx_valid_o);
            if (m_tx_valid)
                check_word("tx_data_o", m_tx_data, tx_data_o);
            check_flag("locked_o", m_locked, locked_o);
            check_flag("error_o", m_error, error_o);
            check_count("err_count_o", CNT_W'(m_count), err_count_o);
            // Tracker stage counts with the lock state before this word
            if (clear_i)
                m_count = 0;
            else if (m_stat_valid && m_locked && !m_stat_zero)
            begin
                m_count = m_count + m_stat_pop;
                if (m_count > CNT_MAX)
                    m_count = CNT_MAX;
            end
            if (m_stat_valid)
            begin
                m_error = (m_stat_pop != 0) || m_stat_zero;
                m_good  = m_error ? 0 : m_good + 1;
                m_bad   = m_error ? m_bad + 1 : 0;
                if (m_good >= LOCK_WORDS)
                    m_locked = 1'b1;
                if (m_bad >= 4)
                    m_locked = 1'b0;
            end
            // Checker stage reads the word now on the mux
            cin_valid    = loopback_i ? m_tx_valid : rx_valid_i;
            cin_data     = loopback_i ? m_tx_data : rx_data_i;
            m_stat_valid = cin_valid;
            if (cin_valid)
            begin
                m_stat_zero = (m_hist == '0);
                m_stat_pop  = count_flagged_bits(m_hist, cin_data);
                m_hist      = cin_data[W-1:W-ORDER];
            end
            // Generator stage where injection never touches the LFSR
            m_tx_valid = gen_en_i;
            if (gen_en_i)
            begin
                clean_word = next_prbs_word(m_lfsr);
                m_tx_data  = inject_i ? (clean_word ^ (W'(1) << inject_pos_i)) : clean_word;
                m_lfsr     = clean_word[W-1:W-ORDER];
            end
        end
    end

    // ==============================
    // Stimulus
    // ==============================
    task automatic wait_for_lock(input int max_cycles);
        int waited;
        waited = 0;
        while (locked_o !== 1'b1 && waited < max_cycles)
        begin
            @(negedge clk_i);
            waited++;
        end
        if (locked_o !== 1'b1)
        begin
            $display("locked_o stayed low for %0d cycles of clean loopback", max_cycles);
            $display("Checks failed");
            $fatal(1, "no lock");
        end
    endtask

    // Single flip gives three flags in total once the gap has passed
    task automatic inject_one_error();
        logic [CNT_W-1:0] cnt_before;
        int               gap;
        @(negedge clk_i);
        cnt_before = err_count_o;
        gap        = 3 + int'($urandom % 4);
        @(posedge clk_i);
        inject_i     <= 1'b1;
        inject_pos_i <= 3'($urandom % 8);
        @(posedge clk_i);
        inject_i <= 1'b0;
        repeat (gap + 2) @(posedge clk_i);
        @(negedge clk_i);
        check_count("err_count_o", cnt_before + CNT_W'(3), err_count_o);
    endtask

    initial
    begin : stimulus
        logic [CNT_W-1:0] cnt_frozen;
        void'($urandom(73139));
        clk_i        = 1'b0;
        resetn_i     = 1'b0;
        gen_en_i     = 1'b0;
        inject_i     = 1'b0;
        inject_pos_i = '0;
        loopback_i   = 1'b1;
        rx_data_i    = '0;
        rx_valid_i   = 1'b0;
        clear_i      = 1'b0;
        repeat (8) @(posedge clk_i);
        resetn_i <= 1'b1;
        @(negedge clk_i);
        check_flag("error_o", 1'b1, error_o);
        check_flag("locked_o", 1'b0, locked_o);
        check_count("err_count_o", '0, err_count_o);
        check_flag("tx_valid_o", 1'b0, tx_valid_o);

        // Loopback with lock within LOCK_WORDS+1 words plus pipeline fill
        @(posedge clk_i);
        gen_en_i <= 1'b1;
        wait_for_lock(LOCK_WORDS + 5);
        repeat (24) @(negedge clk_i);
        check_flag("error_o", 1'b0, error_o);
        check_count("err_count_o", '0, err_count_o);
        repeat (N_INJ) inject_one_error();
        check_flag("locked_o", 1'b1, locked_o);

        // External all-zero data drops lock on the fourth word
        @(posedge clk_i);
        loopback_i <= 1'b0;
        rx_valid_i <= 1'b1;
        rx_data_i  <= '0;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        check_flag("locked_o", 1'b1, locked_o);
        @(negedge clk_i);
        check_flag("locked_o", 1'b0, locked_o);
        check_flag("error_o", 1'b1, error_o);
        cnt_frozen = err_count_o;
        repeat (12) @(negedge clk_i);
        check_count("err_count_o", cnt_frozen, err_count_o);

        // Clear and then loopback again from a zero count
        @(posedge clk_i);
        clear_i <= 1'b1;
        @(posedge clk_i);
        clear_i <= 1'b0;
        @(negedge clk_i);
        check_count("err_count_o", '0, err_count_o);
        @(posedge clk_i);
        loopback_i <= 1'b1;
        rx_valid_i <= 1'b0;
        wait_for_lock(LOCK_WORDS + 6);
        check_count("err_count_o", '0, err_count_o);
        inject_one_error();
        check_count("err_count_o", CNT_W'(3), err_count_o);
        $display("All checks passed");
        $finish;
    end

    // Watchdog
    initial
    begin
        #((PLAN_CYCLES + 100) * CLK_PERIOD);
        $display("Watchdog expired before the test sequence finished");
        $display("Checks failed");
        $fatal(1, "watchdog");
    end

endmodule

`default_nettype wire

//--- design/prbs_bist.sv
// PRBS-7 built-in self-test top level.
// Generator output goes to tx_data_o and, in loopback, straight into
// the checker; otherwise the checker reads rx_data_i. Loopback latency
// from gen_en_i to error_o / err_count_o is three cycles.

`default_nettype none

module prbs_bist #(
    parameter int LOCK_WORDS = 8,
    parameter int CNT_W      = 16
) (
    input  wire logic                          clk_i,
    input  wire logic                          resetn_i,
    input  wire logic                          gen_en_i,
    input  wire logic                          inject_i,
    input  wire logic [2:0]                    inject_pos_i,
    input  wire logic                          loopback_i,
    input  wire logic [prbs_pkg::DATA_W-1:0]   rx_data_i,
    input  wire logic                          rx_valid_i,
    input  wire logic                          clear_i,
    output logic      [prbs_pkg::DATA_W-1:0]   tx_data_o,
    output logic                               tx_valid_o,
    output logic                               locked_o,
    output logic                               error_o,
    output logic      [CNT_W-1:0]              err_count_o
);

    // ==============================
    // Internal word paths
    // ==============================
    prbs_pkg::prbs_word_t tx_word;
    prbs_pkg::prbs_word_t chk_word;
    prbs_pkg::chk_stat_t  chk_stat;

    // Generator
    prbs_gen prbs_gen_inst (
        .clk_i        (clk_i),
        .resetn_i     (resetn_i),
        .gen_en_i     (gen_en_i),
        .inject_i     (inject_i),
        .inject_pos_i (inject_pos_i),
        .word_o       (tx_word)
    );

    assign tx_data_o  = tx_word.data;
    assign tx_valid_o = tx_word.valid;

    // Loopback mux, unregistered
    always_comb
    begin
        if (loopback_i)
            chk_word = tx_word;
        else
            chk_word = '{valid: rx_valid_i, data: rx_data_i};
    end

    // Checker
    prbs_check prbs_check_inst (
        .clk_i    (clk_i),
        .resetn_i (resetn_i),
        .word_i   (chk_word),
        .stat_o   (chk_stat)
    );

    // Lock and error accounting
    prbs_err_track #(
        .LOCK_WORDS (LOCK_WORDS),
        .CNT_W      (CNT_W)
    ) prbs_err_track_inst (
        .clk_i       (clk_i),
        .resetn_i    (resetn_i),
        .stat_i      (chk_stat),
        .clear_i     (clear_i),
        .locked_o    (locked_o),
        .error_o     (error_o),
        .err_count_o (err_count_o)
    );

endmodule

`default_nettype wire

//--- design/prbs_err_track.sv
// Lock tracking and error accounting behind the PRBS checker.
// Lock comes after LOCK_WORDS clean words in a row and goes after four
// unclean ones. While locked, flagged bits are summed into a saturating
// counter; clear_i zeroes it. error_o shows the latest word's status.

`default_nettype none

module prbs_err_track #(
    parameter int LOCK_WORDS = 8,
    parameter int CNT_W      = 16
) (
    input  wire logic                clk_i,
    input  wire logic                resetn_i,
    input  wire prbs_pkg::chk_stat_t stat_i,
    input  wire logic                clear_i,
    output logic                     locked_o,
    output logic                     error_o,
    output logic [CNT_W-1:0]         err_count_o
);

    localparam int W       = prbs_pkg::DATA_W;
    localparam int GOOD_W  = $clog2(LOCK_WORDS + 1);
    localparam int POP_W   = $clog2(W + 1);
    // Unclean words in a row that drop lock
    localparam int UNLOCK_WORDS = 4;

    // ==============================
    // Word classification
    // ==============================
    logic              clean;
    logic [POP_W-1:0]  pop;
    logic [CNT_W:0]    sum;
    logic [GOOD_W-1:0] good_cnt_q;
    logic [1:0]        bad_cnt_q;

    assign clean = (stat_i.err_bits == '0) && !stat_i.zero_hist;

    // Flagged bits in this word, zero_hist words add nothing
    always_comb
    begin
        pop = '0;
        if (!stat_i.zero_hist)
        begin
            for (int i = 0; i < W; i++)
                pop = pop + POP_W'(stat_i.err_bits[i]);
        end
    end

    // One extra bit catches the carry out
    assign sum = {1'b0, err_count_o} + (CNT_W+1)'(pop);

    // ==============================
    // Lock FSM and counters
    // ==============================
    always_ff @(posedge clk_i or negedge resetn_i)
    begin
        if (!resetn_i)
        begin
            good_cnt_q  <= '0;
            bad_cnt_q   <= '0;
            locked_o    <= 1'b0;
            error_o     <= 1'b1;
            err_count_o <= '0;
        end
        else
        begin
            if (stat_i.valid)
            begin
                error_o <= !clean;
                if (clean)
                begin
                    bad_cnt_q <= '0;
                    if (good_cnt_q == GOOD_W'(LOCK_WORDS - 1))
                        locked_o <= 1'b1;
                    // Saturate at the lock threshold
                    if (good_cnt_q != GOOD_W'(LOCK_WORDS))
                        good_cnt_q <= good_cnt_q + 1'b1;
                end
                else
                begin
                    good_cnt_q <= '0;
                    if (bad_cnt_q == 2'(UNLOCK_WORDS - 1))
                        locked_o <= 1'b0;
                    else
                        bad_cnt_q <= bad_cnt_q + 1'b1;
                end
            end

            // Clear wins over accumulation
            if (clear_i)
                err_count_o <= '0;
            else if (stat_i.valid && locked_o)
                err_count_o <= sum[CNT_W] ? '1 : sum[CNT_W-1:0];
        end
    end

    // Counter only moves up unless cleared
    a_no_wrap : assert property (
        @(posedge clk_i) disable iff (!resetn_i)
        !clear_i |=> err_count_o >= $past(err_count_o)
    );

endmodule

`default_nettype wire

//--- design/prbs_check.sv
// Parallel self-synchronizing PRBS-7 checker.
// Each received bit is predicted from the seven bits before it; a
// mismatch sets that bit's error flag. The history follows the received
// data, so the checker locks on by itself after one clean history.
// Results are registered one cycle after each valid word.

`default_nettype none

module prbs_check (
    input  wire logic                 clk_i,
    input  wire logic                 resetn_i,
    input  wire prbs_pkg::prbs_word_t word_i,
    output prbs_pkg::chk_stat_t       stat_o
);

    localparam int W     = prbs_pkg::DATA_W;
    localparam int ORDER = prbs_pkg::PRBS_ORDER;
    localparam int TAP   = prbs_pkg::PRBS_TAP;

    // ==============================
    // History and extended word
    // ==============================
    // Last ORDER received bits, bit 0 oldest
    logic [ORDER-1:0]   hist_q;
    // Current word on top, history below
    logic [W+ORDER-1:0] ext;
    logic [W-1:0]       err_next;
    logic               zero_next;

    assign ext = {word_i.data, hist_q};

    // Each bit against the bits 6 and 7 positions earlier
    always_comb
    begin
        for (int i = 0; i < W; i++)
            err_next[i] = ext[i+ORDER] ^ ext[i+ORDER-TAP] ^ ext[i];
    end

    // Predictions are meaningless on an all-zero history
    assign zero_next = ~(|hist_q);

    // ==============================
    // Registers
    // ==============================
    always_ff @(posedge clk_i or negedge resetn_i)
    begin
        if (!resetn_i)
        begin
            hist_q <= '0;
            stat_o <= '0;
        end
        else
        begin
            stat_o.valid <= word_i.valid;
            if (word_i.valid)
            begin
                stat_o.err_bits  <= err_next;
                stat_o.zero_hist <= zero_next;
                // Newest ORDER bits become history
                hist_q <= ext[W+ORDER-1:W];
            end
        end
    end

    // Result strobe trails the input strobe by exactly one cycle
    a_valid_lat : assert property (
        @(posedge clk_i) disable iff (!resetn_i)
        word_i.valid |=> stat_o.valid
    );

    a_no_spurious : assert property (
        @(posedge clk_i) disable iff (!resetn_i)
        !word_i.valid |=> !stat_o.valid
    );

endmodule

`default_nettype wire

//--- design/prbs_gen.sv
// Parallel PRBS-7 word generator.
// Each enabled cycle emits DATA_W new sequence bits, registered.
// A pulse on inject_i flips one bit of that word without disturbing
// the LFSR, so the sequence itself stays intact.

`default_nettype none

module prbs_gen (
    input  wire logic            clk_i,
    input  wire logic            resetn_i,
    input  wire logic            gen_en_i,
    input  wire logic            inject_i,
    input  wire logic [2:0]      inject_pos_i,
    output prbs_pkg::prbs_word_t word_o
);

    localparam int W     = prbs_pkg::DATA_W;
    localparam int ORDER = prbs_pkg::PRBS_ORDER;
    localparam int TAP   = prbs_pkg::PRBS_TAP;

    // ==============================
    // LFSR state and next word
    // ==============================
    // Last ORDER output bits with bit 0 oldest
    logic [ORDER-1:0] state_q;
    logic [ORDER-1:0] state_next;
    logic [W-1:0]     data_next;
    logic [W-1:0]     inject_mask;

    // Unroll W single-bit steps
    always_comb
    begin
        logic [ORDER-1:0] s;
        logic             nb;
        s = state_q;
        for (int i = 0; i < W; i++)
        begin
            // b[n] = b[n-7] ^ b[n-6]
            nb           = s[0] ^ s[ORDER-TAP];
            data_next[i] = nb;
            s            = {nb, s[ORDER-1:1]};
        end
        state_next = s;
    end

    // One-hot flip position
    assign inject_mask = {{(W-1){1'b0}}, 1'b1} << inject_pos_i;

    // ==============================
    // Registers
    // ==============================
    always_ff @(posedge clk_i or negedge resetn_i)
    begin
        if (!resetn_i)
        begin
            state_q <= prbs_pkg::PRBS_SEED;
            word_o  <= '0;
        end
        else
        begin
            word_o.valid <= gen_en_i;
            if (gen_en_i)
            begin
                state_q     <= state_next;
                // Word payload with the optional single-bit flip
                word_o.data <= inject_i ? (data_next ^ inject_mask) : data_next;
            end
        end
    end

    // LFSR must never collapse into the all-zero lockup state
    a_state_nonzero : assert property (
        @(posedge clk_i) disable iff (!resetn_i) state_q != '0
    );

endmodule

`default_nettype wire

//--- design/prbs_pkg.sv
// Shared constants and word structs for the PRBS-7 built-in self-test.
// Generator, checker, error tracker and top level all reference this
// package by scoped names.

`default_nettype none

package prbs_pkg;

    // ==============================
    // Polynomial x^7 + x^6 + 1
    // ==============================
    // Bits moved per clock
    localparam int DATA_W = 8;
    // Order, also history length
    localparam int PRBS_ORDER = 7;
    // Inner tap
    localparam int PRBS_TAP = 6;
    // Generator reset state, must be nonzero
    localparam logic [PRBS_ORDER-1:0] PRBS_SEED = '1;

    // ==============================
    // Shared word types
    // ==============================
    // One parallel word, bit 0 oldest in time
    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] data;
    } prbs_word_t;

    // Checker result for one word
    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] err_bits;
        logic              zero_hist;
    } chk_stat_t;

endpackage

`default_nettype wire
